// ==== include/exec_defs.svh ====
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Datapath widths
`define SIZE_DATA         32
`define SIZE_IMMEDIATE    16
`define SIZE_OPCODE_I     6
`define SIZE_PHYSICAL_LOG 6

// Execution flags word
`define EXECUTION_FLAGS   6

// Bit positions inside the execution flags word
`define FLAG_MISPREDICT   0
`define FLAG_EXCEPTION    1
`define FLAG_EXECUTED     2
`define FLAG_CTRL         3
`define FLAG_DEST_VALID   4
`define FLAG_MEM          5

`endif

// ==== hw/alu_isa_pkg.sv ====
`include "exec_defs.svh"

package alu_isa_pkg;

    // Operand and result word
    typedef logic [`SIZE_DATA-1:0] data_t;

    typedef logic [`SIZE_IMMEDIATE-1:0] immd_t;

    // Physical register tag, tag 0 is the zero register
    typedef logic [`SIZE_PHYSICAL_LOG-1:0] phys_tag_t;

    // Integer opcodes, encodings are fixed by the decoder
    typedef enum logic [`SIZE_OPCODE_I-1:0] {
        ADD   = 6'd1,
        ADDI  = 6'd2,
        ADDU  = 6'd3,
        ADDIU = 6'd4,
        SUB   = 6'd5,
        SUBU  = 6'd6,
        MFHI  = 6'd7,
        MTHI  = 6'd8,
        MFLO  = 6'd9,
        MTLO  = 6'd10,
        AND_  = 6'd11,
        ANDI  = 6'd12,
        OR    = 6'd13,
        ORI   = 6'd14,
        XOR   = 6'd15,
        XORI  = 6'd16,
        NOR   = 6'd17,
        SLL   = 6'd18,
        SLLV  = 6'd19,
        SRL   = 6'd20,
        SRLV  = 6'd21,
        SRA   = 6'd22,
        SRAV  = 6'd23,
        SLT   = 6'd24,
        SLTI  = 6'd25,
        SLTU  = 6'd26,
        SLTIU = 6'd27,
        LUI   = 6'd28,
        NOP   = 6'd29
    } alu_opcode_t;

endpackage

// ==== hw/exec_flags_pkg.sv ====
`include "exec_defs.svh"

package exec_flags_pkg;

    typedef logic [`EXECUTION_FLAGS-1:0] exec_flags_t;

    // The simple lane never mispredicts and never touches memory
    function automatic exec_flags_t make_exec_flags(
        input logic exception,
        input logic dest_valid
    );
        exec_flags_t flags;
        flags                   = '0;
        flags[`FLAG_MISPREDICT] = 1'b0;
        flags[`FLAG_EXCEPTION]  = exception;
        flags[`FLAG_EXECUTED]   = 1'b1;
        flags[`FLAG_CTRL]       = 1'b0;
        flags[`FLAG_DEST_VALID] = dest_valid;
        flags[`FLAG_MEM]        = 1'b0;
        return flags;
    endfunction

endpackage

// ==== hw/simple_alu.sv ====
`include "exec_defs.svh"

module simple_alu
    import alu_isa_pkg::*;
    import exec_flags_pkg::*;
(
    input  data_t       data1_i,
    input  data_t       data2_i,
    input  immd_t       immd_i,
    input  alu_opcode_t opcode_i,
    output data_t       result_o,
    output exec_flags_t flags_o
);

    data_t      sext_immd;
    data_t      zext_immd;
    logic [4:0] shamt_immd;
    logic [4:0] shamt_reg;

    data_t      sum_reg;
    data_t      sum_immd;
    data_t      diff_reg;
    logic       ovf_add;
    logic       ovf_addi;
    logic       ovf_sub;

    logic       lt_signed;
    logic       lt_signed_immd;
    logic       lt_unsigned;
    logic       lt_unsigned_immd;

    data_t      result;
    logic       exception;
    logic       dest_valid;
    logic       known_op;

    // Immediate forms
    assign sext_immd  = {{(`SIZE_DATA-`SIZE_IMMEDIATE){immd_i[`SIZE_IMMEDIATE-1]}}, immd_i};
    assign zext_immd  = {{(`SIZE_DATA-`SIZE_IMMEDIATE){1'b0}}, immd_i};
    assign shamt_immd = immd_i[4:0];
    assign shamt_reg  = data1_i[4:0];

    // Adders shared by the signed and unsigned variants
    assign sum_reg  = data1_i + data2_i;
    assign sum_immd = data1_i + sext_immd;
    assign diff_reg = data1_i - data2_i;

    // Signed overflow: operands agree in sign but the result does not
    assign ovf_add  = (data1_i[`SIZE_DATA-1] == data2_i[`SIZE_DATA-1]) &&
                      (sum_reg[`SIZE_DATA-1] != data1_i[`SIZE_DATA-1]);
    assign ovf_addi = (data1_i[`SIZE_DATA-1] == sext_immd[`SIZE_DATA-1]) &&
                      (sum_immd[`SIZE_DATA-1] != data1_i[`SIZE_DATA-1]);
    // For subtract the operand signs must differ
    assign ovf_sub  = (data1_i[`SIZE_DATA-1] != data2_i[`SIZE_DATA-1]) &&
                      (diff_reg[`SIZE_DATA-1] != data1_i[`SIZE_DATA-1]);

    assign lt_signed        = $signed(data1_i) < $signed(data2_i);
    assign lt_signed_immd   = $signed(data1_i) < $signed(sext_immd);
    assign lt_unsigned      = data1_i < data2_i;
    assign lt_unsigned_immd = data1_i < zext_immd;

    always_comb begin
        result     = '0;
        exception  = 1'b0;
        dest_valid = 1'b1;
        known_op   = 1'b1;
        case (opcode_i)
            ADD: begin
                result    = sum_reg;
                exception = ovf_add;
            end
            ADDI: begin
                result    = sum_immd;
                exception = ovf_addi;
            end
            ADDU:  result = sum_reg;
            ADDIU: result = sum_immd;
            SUB: begin
                result    = diff_reg;
                exception = ovf_sub;
            end
            SUBU:  result = diff_reg;
            // HI/LO moves just carry operand 1 through
            MFHI:  result = data1_i;
            MTHI:  result = data1_i;
            MFLO:  result = data1_i;
            MTLO:  result = data1_i;
            AND_:  result = data1_i & data2_i;
            ANDI:  result = data1_i & zext_immd;
            OR:    result = data1_i | data2_i;
            ORI:   result = data1_i | zext_immd;
            XOR:   result = data1_i ^ data2_i;
            XORI:  result = data1_i ^ zext_immd;
            NOR:   result = ~(data1_i | data2_i);
            SLL:   result = data1_i << shamt_immd;
            SLLV:  result = data2_i << shamt_reg;
            SRL:   result = data1_i >> shamt_immd;
            SRLV:  result = data2_i >> shamt_reg;
            SRA:   result = $signed(data1_i) >>> shamt_immd;
            SRAV:  result = $signed(data2_i) >>> shamt_reg;
            SLT:   result = {{(`SIZE_DATA-1){1'b0}}, lt_signed};
            SLTI:  result = {{(`SIZE_DATA-1){1'b0}}, lt_signed_immd};
            SLTU:  result = {{(`SIZE_DATA-1){1'b0}}, lt_unsigned};
            SLTIU: result = {{(`SIZE_DATA-1){1'b0}}, lt_unsigned_immd};
            LUI:   result = {immd_i, {(`SIZE_DATA-`SIZE_IMMEDIATE){1'b0}}};
            NOP: begin
                dest_valid = 1'b0;
            end
            default: begin
                dest_valid = 1'b0;
                known_op   = 1'b0;
            end
        endcase
    end

    assign result_o = result;
    // Undecoded opcodes report nothing, not even executed
    assign flags_o  = known_op ? make_exec_flags(exception, dest_valid) : '0;

endmodule

// ==== hw/exec_issue_stage.sv ====
module exec_issue_stage
    import alu_isa_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        issue_valid_i,
    input  alu_opcode_t issue_opcode_i,
    input  data_t       issue_data1_i,
    input  data_t       issue_data2_i,
    input  immd_t       issue_immd_i,
    input  phys_tag_t   issue_src1_tag_i,
    input  phys_tag_t   issue_src2_tag_i,
    input  phys_tag_t   issue_dest_tag_i,
    input  logic        wb_valid_i,
    input  logic        wb_dest_valid_i,
    input  phys_tag_t   wb_dest_tag_i,
    input  data_t       wb_result_i,
    output logic        exe_valid_o,
    output alu_opcode_t exe_opcode_o,
    output data_t       exe_data1_o,
    output data_t       exe_data2_o,
    output immd_t       exe_immd_o,
    output phys_tag_t   exe_dest_tag_o
);

    logic        valid_q;
    alu_opcode_t opcode_q;
    data_t       data1_q;
    data_t       data2_q;
    immd_t       immd_q;
    phys_tag_t   src1_tag_q;
    phys_tag_t   src2_tag_q;
    phys_tag_t   dest_tag_q;

    logic        wb_fwd_ok;
    logic        bypass1;
    logic        bypass2;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid_i;
        end
    end

    // Payload is captured every cycle, valid_q qualifies it
    always_ff @(posedge clk) begin
        opcode_q   <= issue_opcode_i;
        data1_q    <= issue_data1_i;
        data2_q    <= issue_data2_i;
        immd_q     <= issue_immd_i;
        src1_tag_q <= issue_src1_tag_i;
        src2_tag_q <= issue_src2_tag_i;
        dest_tag_q <= issue_dest_tag_i;
    end

    // Only the instruction one cycle ahead can forward, never the zero register
    assign wb_fwd_ok = wb_valid_i && wb_dest_valid_i && (wb_dest_tag_i != '0);
    assign bypass1   = wb_fwd_ok && (src1_tag_q == wb_dest_tag_i);
    assign bypass2   = wb_fwd_ok && (src2_tag_q == wb_dest_tag_i);

    assign exe_valid_o    = valid_q;
    assign exe_opcode_o   = opcode_q;
    assign exe_data1_o    = bypass1 ? wb_result_i : data1_q;
    assign exe_data2_o    = bypass2 ? wb_result_i : data2_q;
    assign exe_immd_o     = immd_q;
    assign exe_dest_tag_o = dest_tag_q;

endmodule

// ==== hw/exec_writeback_stage.sv ====
`include "exec_defs.svh"

module exec_writeback_stage
    import alu_isa_pkg::*;
    import exec_flags_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        exe_valid_i,
    input  phys_tag_t   exe_dest_tag_i,
    input  data_t       alu_result_i,
    input  exec_flags_t alu_flags_i,
    output logic        wb_valid_o,
    output logic        wb_dest_valid_o,
    output data_t       wb_result_o,
    output exec_flags_t wb_flags_o,
    output phys_tag_t   wb_dest_tag_o
);

    logic        valid_q;
    exec_flags_t flags_q;
    data_t       result_q;
    phys_tag_t   dest_tag_q;

    // Flags of an empty slot read as zero
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            flags_q <= '0;
        end else begin
            valid_q <= exe_valid_i;
            flags_q <= exe_valid_i ? alu_flags_i : '0;
        end
    end

    always_ff @(posedge clk) begin
        result_q   <= alu_result_i;
        dest_tag_q <= exe_dest_tag_i;
    end

    assign wb_valid_o      = valid_q;
    assign wb_flags_o      = flags_q;
    assign wb_result_o     = result_q;
    assign wb_dest_tag_o   = dest_tag_q;
    // Dest-valid for the bypass path in the issue stage
    assign wb_dest_valid_o = flags_q[`FLAG_DEST_VALID];

endmodule

// ==== hw/int_exec_top.sv ====
module int_exec_top
    import alu_isa_pkg::*;
    import exec_flags_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        issue_valid_i,
    input  alu_opcode_t issue_opcode_i,
    input  data_t       issue_data1_i,
    input  data_t       issue_data2_i,
    input  immd_t       issue_immd_i,
    input  phys_tag_t   issue_src1_tag_i,
    input  phys_tag_t   issue_src2_tag_i,
    input  phys_tag_t   issue_dest_tag_i,
    output logic        wb_valid_o,
    output data_t       wb_result_o,
    output exec_flags_t wb_flags_o,
    output phys_tag_t   wb_dest_tag_o
);

    logic        exe_valid;
    alu_opcode_t alu_opcode;
    data_t       alu_data1;
    data_t       alu_data2;
    immd_t       alu_immd;
    phys_tag_t   exe_dest_tag;
    data_t       alu_result;
    exec_flags_t alu_flags;
    logic        wb_dest_valid;

    // Writeback outputs loop back for one-cycle bypass
    exec_issue_stage i_exec_issue_stage (
        .clk              (clk),
        .reset_i          (reset_i),
        .issue_valid_i    (issue_valid_i),
        .issue_opcode_i   (issue_opcode_i),
        .issue_data1_i    (issue_data1_i),
        .issue_data2_i    (issue_data2_i),
        .issue_immd_i     (issue_immd_i),
        .issue_src1_tag_i (issue_src1_tag_i),
        .issue_src2_tag_i (issue_src2_tag_i),
        .issue_dest_tag_i (issue_dest_tag_i),
        .wb_valid_i       (wb_valid_o),
        .wb_dest_valid_i  (wb_dest_valid),
        .wb_dest_tag_i    (wb_dest_tag_o),
        .wb_result_i      (wb_result_o),
        .exe_valid_o      (exe_valid),
        .exe_opcode_o     (alu_opcode),
        .exe_data1_o      (alu_data1),
        .exe_data2_o      (alu_data2),
        .exe_immd_o       (alu_immd),
        .exe_dest_tag_o   (exe_dest_tag)
    );

    simple_alu i_simple_alu (
        .data1_i  (alu_data1),
        .data2_i  (alu_data2),
        .immd_i   (alu_immd),
        .opcode_i (alu_opcode),
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

    exec_writeback_stage i_exec_writeback_stage (
        .clk             (clk),
        .reset_i         (reset_i),
        .exe_valid_i     (exe_valid),
        .exe_dest_tag_i  (exe_dest_tag),
        .alu_result_i    (alu_result),
        .alu_flags_i     (alu_flags),
        .wb_valid_o      (wb_valid_o),
        .wb_dest_valid_o (wb_dest_valid),
        .wb_result_o     (wb_result_o),
        .wb_flags_o      (wb_flags_o),
        .wb_dest_tag_o   (wb_dest_tag_o)
    );

endmodule

// ==== sim/int_exec_tb.sv ====
`include "exec_defs.svh"

module int_exec_tb
    import alu_isa_pkg::*;
    import exec_flags_pkg::*;
();

    logic        clk;
    logic        reset_i;
    logic        issue_valid;
    alu_opcode_t issue_opcode;
    data_t       issue_data1;
    data_t       issue_data2;
    immd_t       issue_immd;
    phys_tag_t   issue_src1_tag;
    phys_tag_t   issue_src2_tag;
    phys_tag_t   issue_dest_tag;
    logic        wb_valid;
    data_t       wb_result;
    exec_flags_t wb_flags;
    phys_tag_t   wb_dest_tag;

    // Expected writeback slots per cycle including idle ones
    logic        exp_valid_q[$];
    data_t       exp_result_q[$];
    exec_flags_t exp_flags_q[$];
    phys_tag_t   exp_tag_q[$];

    // Shadow of the previously issued instruction for bypass
    logic        prev_valid;
    logic        prev_dv;
    phys_tag_t   prev_tag;
    data_t       prev_result;

    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    int_exec_top i_int_exec_top (
        .clk              (clk),
        .reset_i          (reset_i),
        .issue_valid_i    (issue_valid),
        .issue_opcode_i   (issue_opcode),
        .issue_data1_i    (issue_data1),
        .issue_data2_i    (issue_data2),
        .issue_immd_i     (issue_immd),
        .issue_src1_tag_i (issue_src1_tag),
        .issue_src2_tag_i (issue_src2_tag),
        .issue_dest_tag_i (issue_dest_tag),
        .wb_valid_o       (wb_valid),
        .wb_result_o      (wb_result),
        .wb_flags_o       (wb_flags),
        .wb_dest_tag_o    (wb_dest_tag)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Reference ALU built from the ISA rules
    task automatic predict_alu(
        input  alu_opcode_t op,
        input  data_t       a,
        input  data_t       b,
        input  immd_t       imm,
        output data_t       res,
        output exec_flags_t flags
    );
        data_t  simm;
        data_t  zimm;
        longint sa;
        longint sb;
        longint si;
        longint wide;
        logic   ovf;
        logic   dv;
        logic   known;
        simm  = {{16{imm[15]}}, imm};
        zimm  = {16'h0000, imm};
        sa    = $signed(a);
        sb    = $signed(b);
        si    = $signed(simm);
        dv    = 1'b1;
        known = 1'b1;
        case (op)
            ADD, ADDU:   wide = sa + sb;
            ADDI, ADDIU: wide = sa + si;
            SUB, SUBU:   wide = sa - sb;
            default:     wide = 0;
        endcase
        // Computed for the unsigned forms too but only the signed ones trap
        ovf = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
        case (op)
            ADD, ADDU, ADDI, ADDIU, SUB, SUBU: res = wide[31:0];
            MFHI, MTHI, MFLO, MTLO:            res = a;
            AND_:    res = a & b;
            ANDI:    res = a & zimm;
            OR:      res = a | b;
            ORI:     res = a | zimm;
            XOR:     res = a ^ b;
            XORI:    res = a ^ zimm;
            NOR:     res = ~(a | b);
            SLL:     res = a << imm[4:0];
            SLLV:    res = b << a[4:0];
            SRL:     res = a >> imm[4:0];
            SRLV:    res = b >> a[4:0];
            SRA:     res = $signed(a) >>> imm[4:0];
            SRAV:    res = $signed(b) >>> a[4:0];
            SLT:     res = (sa < sb) ? 32'd1 : 32'd0;
            SLTI:    res = (sa < si) ? 32'd1 : 32'd0;
            SLTU:    res = (a < b) ? 32'd1 : 32'd0;
            SLTIU:   res = (a < zimm) ? 32'd1 : 32'd0;
            LUI:     res = {imm, 16'h0000};
            NOP: begin
                res = '0;
                dv  = 1'b0;
            end
            default: begin
                res   = '0;
                known = 1'b0;
            end
        endcase
        flags = '0;
        if (known) begin
            flags[`FLAG_EXECUTED]   = 1'b1;
            flags[`FLAG_DEST_VALID] = dv;
            flags[`FLAG_EXCEPTION]  = ovf && (op == ADD || op == ADDI || op == SUB);
        end
    endtask

    task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("Verification failed");
        $finish;
    endtask

    task automatic check_writeback();
        logic v;
        v = exp_valid_q.pop_front();
        check_hex("wb_valid_o", {31'd0, v}, {31'd0, wb_valid});
        check_hex("wb_flags_o", exp_flags_q.pop_front(), wb_flags);
        if (v) begin
            check_hex("wb_result_o", exp_result_q.pop_front(), wb_result);
            check_hex("wb_dest_tag_o", exp_tag_q.pop_front(), wb_dest_tag);
        end else begin
            exp_result_q.pop_front();
            exp_tag_q.pop_front();
        end
    endtask

    // Check the slot issued two cycles ago and then drive the next one
    task automatic issue_cycle(
        input logic        valid,
        input alu_opcode_t op,
        input data_t       d1,
        input data_t       d2,
        input immd_t       imm,
        input phys_tag_t   s1,
        input phys_tag_t   s2,
        input phys_tag_t   dt
    );
        data_t       op1;
        data_t       op2;
        data_t       res;
        exec_flags_t flags;
        logic        fwd;
        @(posedge clk);
        #5;
        if (exp_valid_q.size() >= 2) begin
            check_writeback();
        end
        issue_valid    = valid;
        issue_opcode   = op;
        issue_data1    = d1;
        issue_data2    = d2;
        issue_immd     = imm;
        issue_src1_tag = s1;
        issue_src2_tag = s2;
        issue_dest_tag = dt;
        fwd = prev_valid && prev_dv && (prev_tag != 0);
        op1 = (fwd && s1 == prev_tag) ? prev_result : d1;
        op2 = (fwd && s2 == prev_tag) ? prev_result : d2;
        predict_alu(op, op1, op2, imm, res, flags);
        if (!valid) begin
            flags = '0;
        end
        exp_valid_q.push_back(valid);
        exp_result_q.push_back(res);
        exp_flags_q.push_back(flags);
        exp_tag_q.push_back(dt);
        prev_valid  = valid;
        prev_dv     = flags[`FLAG_DEST_VALID];
        prev_tag    = dt;
        prev_result = res;
    endtask

    task automatic issue_idle();
        issue_cycle(1'b0, NOP, '0, '0, '0, '0, '0, '0);
    endtask

    function automatic logic pending_valid();
        foreach (exp_valid_q[i]) begin
            if (exp_valid_q[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic drain_pipeline();
        int guard;
        guard = 0;
        while (pending_valid() && guard < 8) begin
            issue_idle();
            guard++;
        end
        if (pending_valid()) begin
            abort_run("pipeline did not drain");
        end
    endtask

    task automatic wait_wb_valid(output int cycles);
        cycles = 0;
        while (wb_valid !== 1'b1 && cycles < 10) begin
            issue_idle();
            cycles++;
        end
        if (wb_valid !== 1'b1) begin
            abort_run("wb_valid_o never rose after an issue");
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        drain_pipeline();
        tests_run++;
        if (errors > err_start) begin
            tests_failed++;
            $display("Test %s: FAILED with %0d errors", name, errors - err_start);
        end else begin
            $display("Test %s: ok", name);
        end
    endtask

    initial begin
        int          seed_dummy;
        int          err_start;
        int          lat;
        logic [5:0]  op_bits;
        seed_dummy     = $urandom(32'hf1c);
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        prev_valid     = 1'b0;
        prev_dv        = 1'b0;
        prev_tag       = '0;
        prev_result    = '0;
        reset_i        = 1'b1;
        issue_valid    = 1'b0;
        issue_opcode   = NOP;
        issue_data1    = '0;
        issue_data2    = '0;
        issue_immd     = '0;
        issue_src1_tag = '0;
        issue_src2_tag = '0;
        issue_dest_tag = '0;
        repeat (16) @(posedge clk);
        #5;
        reset_i = 1'b0;

        // Reset state and two-cycle latency of a single ADD
        err_start = errors;
        check_hex("wb_valid_o", 32'd0, {31'd0, wb_valid});
        check_hex("wb_flags_o", 32'd0, wb_flags);
        issue_cycle(1'b1, ADD, 32'h1234_0000, 32'h0000_5678, '0, '0, '0, 6'd5);
        wait_wb_valid(lat);
        if (lat != 2) begin
            errors++;
            $display("ADD reached writeback after %0d cycles instead of 2", lat);
        end
        finish_test("reset_and_latency", err_start);

        // Small tag space makes random bypass frequent
        err_start = errors;
        for (int i = 0; i < 300; i++) begin
            op_bits = ($urandom % 29) + 1;
            issue_cycle(1'b1, alu_opcode_t'(op_bits), $urandom, $urandom, $urandom,
                        $urandom % 8, $urandom % 8, $urandom % 8);
        end
        finish_test("random_ops", err_start);

        err_start = errors;
        issue_cycle(1'b1, ADD, 32'h7fff_ffff, 32'd1, '0, '0, '0, 6'd1);
        issue_cycle(1'b1, ADDU, 32'h7fff_ffff, 32'd1, '0, '0, '0, 6'd1);
        issue_cycle(1'b1, ADDI, 32'h7fff_ffff, '0, 16'h0001, '0, '0, 6'd1);
        issue_cycle(1'b1, SUB, 32'h8000_0000, 32'd1, '0, '0, '0, 6'd1);
        issue_cycle(1'b1, SLT, 32'hffff_ffff, 32'd1, '0, '0, '0, 6'd1);
        issue_cycle(1'b1, SLT, 32'd1, 32'hffff_ffff, '0, '0, '0, 6'd1);
        issue_cycle(1'b1, SLTI, 32'hffff_fffb, '0, 16'h0003, '0, '0, 6'd1);
        issue_cycle(1'b1, SLTI, 32'd5, '0, 16'hfff0, '0, '0, 6'd1);
        issue_cycle(1'b1, SLTIU, 32'h0001_0000, '0, 16'hffff, '0, '0, 6'd1);
        finish_test("overflow_and_slt", err_start);

        // Register shift amounts above 31 keep only the low 5 bits
        err_start = errors;
        issue_cycle(1'b1, SRA, 32'h8000_0010, '0, 16'h0004, '0, '0, 6'd2);
        issue_cycle(1'b1, SRAV, 32'h0000_0024, 32'h8000_0000, '0, '0, '0, 6'd2);
        issue_cycle(1'b1, SLLV, 32'hffff_ffe3, 32'd1, '0, '0, '0, 6'd2);
        issue_cycle(1'b1, SRLV, 32'h0000_0021, 32'h8000_0000, '0, '0, '0, 6'd2);
        finish_test("shifts", err_start);

        err_start = errors;
        issue_cycle(1'b1, ADD, 32'd5, 32'd7, '0, '0, '0, 6'd10);
        issue_cycle(1'b1, ADD, 32'd100, 32'd200, '0, 6'd10, 6'd10, 6'd11);
        issue_cycle(1'b1, SUB, 32'd1000, 32'd3, '0, '0, 6'd11, 6'd12);
        issue_cycle(1'b1, NOP, 32'd77, 32'd88, '0, '0, '0, 6'd13);
        issue_cycle(1'b1, ADD, 32'd40, 32'd2, '0, 6'd13, 6'd13, 6'd14);
        issue_cycle(1'b1, ORI, 32'h55, '0, 16'h0f00, '0, '0, 6'd0);
        issue_cycle(1'b1, ADD, 32'd1, 32'd2, '0, 6'd0, 6'd0, 6'd15);
        issue_cycle(1'b1, ADD, 32'd9, 32'd9, '0, '0, '0, 6'd16);
        // Bubble slot keeps the dest tag and payload but carries no valid
        issue_cycle(1'b0, ADD, 32'd9, 32'd9, '0, '0, '0, 6'd16);
        issue_cycle(1'b1, ADD, 32'd3, 32'd4, '0, 6'd16, 6'd16, 6'd17);
        finish_test("bypass", err_start);

        err_start = errors;
        issue_cycle(1'b1, NOP, 32'hdead_beef, 32'h1234, 16'hffff, '0, '0, 6'd20);
        finish_test("nop", err_start);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
hw/alu_isa_pkg.sv
hw/exec_flags_pkg.sv
hw/simple_alu.sv
hw/exec_issue_stage.sv
hw/exec_writeback_stage.sv
hw/int_exec_top.sv
sim/int_exec_tb.sv
